//--- ff_control.sv
`timescale 1ns/1ps
`default_nettype none

module ff_control #(
    parameter int tap_limit = 3200000
) (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire gbcore_pkg::settings_t  settings,
    input  wire gbcore_pkg::dl_sel_t    dl_sel,
    input  wire                         ff_button,
    input  wire gbcore_pkg::audio_t     audio_in,
    output logic                        fast_forward,
    output gbcore_pkg::audio_t          audio_out
);

    localparam int cnt_w = (tap_limit > 1) ? $clog2(tap_limit + 1) : 1;

    logic             ff_req;
    logic             req_prev;
    logic             was_tapped;
    logic             ff_latch;
    logic [cnt_w-1:0] hold_cnt;

    // button ignored while a file is loading
    assign ff_req = ff_button && settings.ff_en && !dl_sel.active;

    ////////////////////////////////////////////////////////////////////////////
    // tap latch

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            req_prev     <= 1'b0;
            was_tapped   <= 1'b0;
            ff_latch     <= 1'b0;
            hold_cnt     <= '0;
            fast_forward <= 1'b0;
        end else begin
            req_prev <= ff_req;

            // saturates so a long hold never wraps back into a tap
            if (ff_req && (hold_cnt != cnt_w'(tap_limit))) begin
                hold_cnt <= hold_cnt + 1'b1;
            end

            // new press
            if (ff_req && !req_prev) begin
                ff_latch <= 1'b0;
                hold_cnt <= '0;
            end

            // release, a short press latches unless it ended a latched tap
            if (!ff_req && req_prev) begin
                was_tapped <= 1'b0;
                if ((hold_cnt < cnt_w'(tap_limit)) && !was_tapped) begin
                    was_tapped <= 1'b1;
                    ff_latch   <= 1'b1;
                end
            end

            fast_forward <= ff_req || ff_latch;
        end
    end

    // mute unless sound is wanted at speed
    always_comb begin
        audio_out = audio_in;
        if (fast_forward && !settings.ff_snd_en) begin
            audio_out = '0;
        end
    end

endmodule

`default_nettype wire

//--- gbcore_macros.svh
`ifndef GBCORE_MACROS_SVH
`define GBCORE_MACROS_SVH

// bridge register map, one word per setting
`define ADDR_RESET          32'h0000_0050
`define ADDR_RUMBLE         32'h0000_0204
`define ADDR_COLORS         32'h0000_0208
`define ADDR_FF_EN          32'h0000_020C
`define ADDR_FF_SND         32'h0000_0210
`define ADDR_TINT           32'h0000_0214
`define ADDR_BORDER         32'h0000_0218
`define ADDR_GRAY           32'h0000_021C

// data slot ids
`define SLOT_CART           16'd1
`define SLOT_BORDER         16'd2
`define SLOT_PALETTE        16'd3
`define SLOT_BOOT_CGB       16'd4
`define SLOT_BOOT_DMG       16'd5
`define SLOT_BOOT_SGB       16'd6

// four 24-bit colours in the top 96 bits, low word unused
`define PALETTE_RESET       128'h8282_1451_7356_305A_5F1A_3B49_0000_0000

`define PALETTE_W           128
`define RGB_W               24
`define AUDIO_W             16

`define BLANK_RGB_NO_BORDER 24'h00_2000
`define HS_DELAY            7

`endif

//--- gbcore_pkg.sv
`default_nettype none

`include "gbcore_macros.svh"

package gbcore_pkg;

    // core settings, each field written at its own bridge address
    typedef struct packed {
        logic       rumble_en;
        logic       original_colors;
        logic       ff_en;
        logic       ff_snd_en;
        logic [1:0] tint;
        logic       sgb_border_en;
        logic       gray_en;
    } settings_t;

    // download selects, decoded from the latched slot id
    typedef struct packed {
        logic active;
        logic cart;
        logic palette;
        logic border;
        logic boot;
    } dl_sel_t;

    // raw picture from the console
    typedef struct packed {
        logic [`RGB_W-1:0] rgb;
        logic              hs;
        logic              vs;
        logic              h_blank;
        logic              v_blank;
    } lcd_t;

    // conditioned picture for the scaler
    typedef struct packed {
        logic [`RGB_W-1:0] rgb;
        logic              de;
        logic              hs;
        logic              vs;
    } video_t;

    typedef struct packed {
        logic signed [`AUDIO_W-1:0] left;
        logic signed [`AUDIO_W-1:0] right;
    } audio_t;

endpackage

`default_nettype wire

//--- gbcore_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_macros.svh"

module gbcore_top #(
    parameter int reset_hold = 1048576,
    parameter int tap_limit  = 3200000
) (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    // bridge and data slots
    input  wire                         bridge_wr,
    input  wire [31:0]                  bridge_addr,
    input  wire [31:0]                  bridge_wr_data,
    input  wire                         dataslot_requestwrite,
    input  wire [15:0]                  dataslot_requestwrite_id,
    input  wire                         dataslot_allcomplete,
    // download stream
    input  wire                         ioctl_wr,
    input  wire [15:0]                  ioctl_dout,
    // right shoulder of controller 1
    input  wire                         ff_button,
    input  wire gbcore_pkg::lcd_t       lcd,
    input  wire gbcore_pkg::audio_t     audio_in,
    output wire gbcore_pkg::settings_t  settings,
    output wire gbcore_pkg::dl_sel_t    dl_sel,
    output wire                         core_reset,
    output wire [`PALETTE_W-1:0]        palette,
    output wire                         fast_forward,
    output wire gbcore_pkg::audio_t     audio_out,
    output wire gbcore_pkg::video_t     video
);

    host_regs #(
        .reset_hold (reset_hold)
    ) u_host_regs (
        .clk_sys                  (clk_sys),
        .rst_n                    (rst_n),
        .bridge_wr                (bridge_wr),
        .bridge_addr              (bridge_addr),
        .bridge_wr_data           (bridge_wr_data),
        .dataslot_requestwrite    (dataslot_requestwrite),
        .dataslot_requestwrite_id (dataslot_requestwrite_id),
        .dataslot_allcomplete     (dataslot_allcomplete),
        .settings                 (settings),
        .dl_sel                   (dl_sel),
        .core_reset               (core_reset)
    );

    palette_store u_palette_store (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .dl_sel     (dl_sel),
        .ioctl_wr   (ioctl_wr),
        .ioctl_dout (ioctl_dout),
        .palette    (palette)
    );

    ff_control #(
        .tap_limit (tap_limit)
    ) u_ff_control (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .settings     (settings),
        .dl_sel       (dl_sel),
        .ff_button    (ff_button),
        .audio_in     (audio_in),
        .fast_forward (fast_forward),
        .audio_out    (audio_out)
    );

    video_out u_video_out (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .lcd      (lcd),
        .settings (settings),
        .video    (video)
    );

endmodule

`default_nettype wire

//--- host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_macros.svh"

module host_regs #(
    parameter int reset_hold = 1048576
) (
    input  wire                     clk_sys,
    input  wire                     rst_n,
    input  wire                     bridge_wr,
    input  wire [31:0]              bridge_addr,
    input  wire [31:0]              bridge_wr_data,
    input  wire                     dataslot_requestwrite,
    input  wire [15:0]              dataslot_requestwrite_id,
    input  wire                     dataslot_allcomplete,
    output gbcore_pkg::settings_t   settings,
    output gbcore_pkg::dl_sel_t     dl_sel,
    output logic                    core_reset
);

    localparam int cnt_w = (reset_hold > 1) ? $clog2(reset_hold + 1) : 1;

    logic [cnt_w-1:0] hold_cnt;
    logic             dl_active;
    logic [15:0]      slot_id;

    ////////////////////////////////////////////////////////////////////////////
    // settings registers

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            settings <= '0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                `ADDR_RUMBLE: settings.rumble_en       <= bridge_wr_data[0];
                `ADDR_COLORS: settings.original_colors <= bridge_wr_data[0];
                `ADDR_FF_EN:  settings.ff_en           <= bridge_wr_data[0];
                `ADDR_FF_SND: settings.ff_snd_en       <= bridge_wr_data[0];
                `ADDR_TINT:   settings.tint            <= bridge_wr_data[1:0];
                `ADDR_BORDER: settings.sgb_border_en   <= bridge_wr_data[0];
                `ADDR_GRAY:   settings.gray_en         <= bridge_wr_data[0];
                default: begin
                end
            endcase
        end
    end

    // reset hold, reloaded by every write to the reset address
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (bridge_wr && (bridge_addr == `ADDR_RESET)) begin
            hold_cnt <= cnt_w'(reset_hold);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // download tracking

    // a new request wins over allcomplete in the same cycle
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            dl_active <= 1'b0;
        end else if (dataslot_requestwrite) begin
            dl_active <= 1'b1;
        end else if (dataslot_allcomplete) begin
            dl_active <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dataslot_requestwrite) begin
            slot_id <= dataslot_requestwrite_id;
        end
    end

    always_comb begin
        dl_sel.active  = dl_active;
        dl_sel.cart    = dl_active && (slot_id == `SLOT_CART);
        dl_sel.palette = dl_active && (slot_id == `SLOT_PALETTE);
        dl_sel.border  = dl_active && (slot_id == `SLOT_BORDER);
        // any of the three boot roms
        dl_sel.boot    = dl_active && ((slot_id == `SLOT_BOOT_CGB) ||
                                       (slot_id == `SLOT_BOOT_DMG) ||
                                       (slot_id == `SLOT_BOOT_SGB));
    end

    // console held in reset while rom or boot image is loading
    assign core_reset = (hold_cnt != '0) || dl_sel.cart || dl_sel.boot;

endmodule

`default_nettype wire

//--- palette_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_macros.svh"

module palette_store (
    input  wire                     clk_sys,
    input  wire                     rst_n,
    input  wire gbcore_pkg::dl_sel_t dl_sel,
    input  wire                     ioctl_wr,
    input  wire [15:0]              ioctl_dout,
    output logic [`PALETTE_W-1:0]   palette
);

    logic load_word;

    // only words of a palette download are taken
    assign load_word = dl_sel.palette && ioctl_wr;

    ////////////////////////////////////////////////////////////////////////////
    // palette shift register

    // colour 1 sits in the top 24 bits, colour 4 ends at bit 32
    // words arrive big endian, so the bytes swap on entry
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            palette <= `PALETTE_RESET;
        end else if (load_word) begin
            palette <= {palette[`PALETTE_W-17:0], ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
gbcore_pkg.sv
host_regs.sv
palette_store.sv
ff_control.sv
video_out.sv
gbcore_top.sv
tb_gbcore.sv

//--- tb_gbcore.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_macros.svh"

module tb_gbcore;

    import gbcore_pkg::*;

    localparam int clk_period = 4;
    localparam int reset_hold = 40;
    localparam int tap_limit  = 50;

    // rough length of each test in clocks
    localparam int settings_cycles = 40;
    localparam int download_cycles = 120;
    localparam int palette_cycles  = 60;
    localparam int ff_cycles       = 260;
    localparam int video_cycles    = 100;
    localparam int margin_cycles   = 200;
    localparam int budget_cycles   = settings_cycles + download_cycles + palette_cycles +
                                     ff_cycles + video_cycles + margin_cycles;

    logic                  clk_sys;
    logic                  rst_n;
    logic                  bridge_wr;
    logic [31:0]           bridge_addr;
    logic [31:0]           bridge_wr_data;
    logic                  dataslot_requestwrite;
    logic [15:0]           dataslot_requestwrite_id;
    logic                  dataslot_allcomplete;
    logic                  ioctl_wr;
    logic [15:0]           ioctl_dout;
    logic                  ff_button;
    lcd_t                  lcd;
    audio_t                audio_in;
    settings_t             settings;
    dl_sel_t               dl_sel;
    logic                  core_reset;
    logic [`PALETTE_W-1:0] palette;
    logic                  fast_forward;
    audio_t                audio_out;
    video_t                video;

    settings_t             exp_set;
    logic [`PALETTE_W-1:0] exp_pal;
    int unsigned           seed;

    gbcore_top #(
        .reset_hold (reset_hold),
        .tap_limit  (tap_limit)
    ) DUT (
        .clk_sys                  (clk_sys),
        .rst_n                    (rst_n),
        .bridge_wr                (bridge_wr),
        .bridge_addr              (bridge_addr),
        .bridge_wr_data           (bridge_wr_data),
        .dataslot_requestwrite    (dataslot_requestwrite),
        .dataslot_requestwrite_id (dataslot_requestwrite_id),
        .dataslot_allcomplete     (dataslot_allcomplete),
        .ioctl_wr                 (ioctl_wr),
        .ioctl_dout               (ioctl_dout),
        .ff_button                (ff_button),
        .lcd                      (lcd),
        .audio_in                 (audio_in),
        .settings                 (settings),
        .dl_sel                   (dl_sel),
        .core_reset               (core_reset),
        .palette                  (palette),
        .fast_forward             (fast_forward),
        .audio_out                (audio_out),
        .video                    (video)
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #(clk_period / 2) clk_sys = ~clk_sys;
        end
    end

    initial begin
        #(budget_cycles * clk_period);
        $display("watchdog expired after %0d clocks, a test did not finish", budget_cycles);
        $display("TEST FAILED");
        $fatal(1, "simulation timed out");
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    task automatic check_settings(input string name, input settings_t exp, input settings_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    task automatic check_dl_sel(input string name, input dl_sel_t exp, input dl_sel_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    task automatic check_video(input string name, input video_t exp, input video_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    task automatic check_audio(input string name, input audio_t exp, input audio_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    task automatic check_palette(input string name, input logic [`PALETTE_W-1:0] exp,
                                 input logic [`PALETTE_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run({name, " mismatch"});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model and drivers

    // one field per register address and nothing for other addresses
    function automatic settings_t apply_write(input settings_t s, input logic [31:0] addr,
                                              input logic [31:0] data);
        settings_t n;
        n = s;
        case (addr)
            `ADDR_RUMBLE: n.rumble_en       = data[0];
            `ADDR_COLORS: n.original_colors = data[0];
            `ADDR_FF_EN:  n.ff_en           = data[0];
            `ADDR_FF_SND: n.ff_snd_en       = data[0];
            `ADDR_TINT:   n.tint            = data[1:0];
            `ADDR_BORDER: n.sgb_border_en   = data[0];
            `ADDR_GRAY:   n.gray_en         = data[0];
            default:      n = s;
        endcase
        return n;
    endfunction

    function automatic dl_sel_t expected_sel(input logic [15:0] id);
        dl_sel_t s;
        s.active  = 1'b1;
        s.cart    = (id == `SLOT_CART);
        s.palette = (id == `SLOT_PALETTE);
        s.border  = (id == `SLOT_BORDER);
        s.boot    = (id >= `SLOT_BOOT_CGB) && (id <= `SLOT_BOOT_SGB);
        return s;
    endfunction

    function automatic logic [7:0] luma(input logic [23:0] rgb);
        int r;
        int g;
        int b;
        int y;
        r = rgb[23:16];
        g = rgb[15:8];
        b = rgb[7:0];
        y = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
        return y[7:0];
    endfunction

    // output expected one clock after l was presented
    function automatic video_t expected_video(input lcd_t l, input logic hs, input logic vs);
        video_t v;
        logic [7:0] y;
        y    = luma(l.rgb);
        v.de = !(l.h_blank || l.v_blank);
        v.hs = hs;
        v.vs = vs;
        if (!v.de) begin
            v.rgb = exp_set.sgb_border_en ? 24'h0 : `BLANK_RGB_NO_BORDER;
        end else if (exp_set.gray_en) begin
            v.rgb = {y, y, y};
        end else begin
            v.rgb = l.rgb;
        end
        return v;
    endfunction

    // drive point sits 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        tick();
        bridge_wr = 1'b0;
        exp_set   = apply_write(exp_set, addr, data);
        check_settings("settings", exp_set, settings);
    endtask

    task automatic start_download(input logic [15:0] id);
        dataslot_requestwrite    = 1'b1;
        dataslot_requestwrite_id = id;
        tick();
        dataslot_requestwrite = 1'b0;
    endtask

    task automatic end_download();
        dataslot_allcomplete = 1'b1;
        tick();
        dataslot_allcomplete = 1'b0;
    endtask

    task automatic write_stream(input logic [15:0] word);
        ioctl_wr   = 1'b1;
        ioctl_dout = word;
        tick();
        ioctl_wr = 1'b0;
    endtask

    // checks first and then new audio for the next clock
    task automatic hold_ff(input logic exp, input int cycles);
        audio_t exp_audio;
        repeat (cycles) begin
            if (exp && !exp_set.ff_snd_en) begin
                exp_audio = '0;
            end else begin
                exp_audio = audio_in;
            end
            check_bit("fast_forward", exp, fast_forward);
            check_audio("audio_out", exp_audio, audio_out);
            audio_in = audio_t'($urandom);
            tick();
        end
    endtask

    task automatic tap(input logic exp_held, input int cycles);
        ff_button = 1'b1;
        tick();
        hold_ff(exp_held, cycles);
        ff_button = 1'b0;
        tick();
    endtask

    task automatic video_cycle(input lcd_t next, input logic exp_hs, input logic exp_vs);
        lcd = next;
        tick();
        check_video("video", expected_video(next, exp_hs, exp_vs), video);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_settings();
        check_settings("settings", '0, settings);
        bridge_write(`ADDR_RUMBLE, 32'h1);
        bridge_write(`ADDR_COLORS, 32'h1);
        bridge_write(`ADDR_FF_EN, 32'h1);
        bridge_write(`ADDR_FF_SND, 32'h1);
        bridge_write(`ADDR_TINT, 32'h2);
        bridge_write(`ADDR_BORDER, 32'h1);
        bridge_write(`ADDR_GRAY, 32'h1);
        // unmapped neighbours
        bridge_write(32'h0000_0220, 32'h0);
        bridge_write(32'h0000_0200, 32'h0);
        bridge_write(32'h0000_1204, 32'h0);
        bridge_write(`ADDR_TINT, 32'hFFFF_FFFD);
        bridge_write(`ADDR_RUMBLE, 32'h0);
        bridge_write(`ADDR_COLORS, 32'h2);
        bridge_write(`ADDR_FF_EN, 32'h0);
        bridge_write(`ADDR_FF_SND, 32'h0);
        bridge_write(`ADDR_BORDER, 32'h0);
        bridge_write(`ADDR_GRAY, 32'h0);
        bridge_write(`ADDR_TINT, 32'h0);
    endtask

    task automatic test_reset_downloads();
        dl_sel_t exp_sel;
        bridge_write(`ADDR_RESET, 32'h1);
        repeat (reset_hold) begin
            check_bit("core_reset", 1'b1, core_reset);
            tick();
        end
        check_bit("core_reset", 1'b0, core_reset);
        // slot 7 is not a known id
        for (int id = 1; id <= 7; id++) begin
            start_download(16'(id));
            exp_sel = expected_sel(16'(id));
            repeat (3) begin
                check_dl_sel("dl_sel", exp_sel, dl_sel);
                check_bit("core_reset", exp_sel.cart || exp_sel.boot, core_reset);
                tick();
            end
            end_download();
            check_dl_sel("dl_sel", '0, dl_sel);
            check_bit("core_reset", 1'b0, core_reset);
        end
    endtask

    task automatic test_palette();
        logic [15:0] word;
        check_palette("palette", exp_pal, palette);
        write_stream(16'($urandom));
        check_palette("palette", exp_pal, palette);
        start_download(`SLOT_BORDER);
        write_stream(16'($urandom));
        end_download();
        check_palette("palette", exp_pal, palette);
        start_download(`SLOT_PALETTE);
        repeat (8) begin
            word = 16'($urandom);
            write_stream(word);
            exp_pal = {exp_pal[`PALETTE_W-17:0], word[7:0], word[15:8]};
            check_palette("palette", exp_pal, palette);
            tick();
            check_palette("palette", exp_pal, palette);
        end
        end_download();
        write_stream(16'($urandom));
        check_palette("palette", exp_pal, palette);
    endtask

    task automatic test_fast_forward();
        bridge_write(`ADDR_FF_EN, 32'h1);
        bridge_write(`ADDR_FF_SND, 32'h0);
        hold_ff(1'b0, 3);
        // short tap latches one clock after the release edge
        tap(1'b1, 5);
        tick();
        hold_ff(1'b1, 10);
        // next press clears it
        tap(1'b1, 4);
        hold_ff(1'b0, 10);
        // long hold never latches
        tap(1'b1, tap_limit + 10);
        hold_ff(1'b0, 10);
        // button dead while a file loads
        start_download(`SLOT_BORDER);
        tap(1'b0, 5);
        hold_ff(1'b0, 5);
        end_download();
        hold_ff(1'b0, 3);
        // latched again with sound toggled at speed
        tap(1'b1, 3);
        tick();
        hold_ff(1'b1, 3);
        bridge_write(`ADDR_FF_SND, 32'h1);
        hold_ff(1'b1, 5);
        bridge_write(`ADDR_FF_SND, 32'h0);
        hold_ff(1'b1, 3);
        tap(1'b1, 2);
        hold_ff(1'b0, 3);
        bridge_write(`ADDR_FF_EN, 32'h0);
        tap(1'b0, 5);
        hold_ff(1'b0, 3);
    endtask

    task automatic test_video();
        lcd_t pix;
        pix = '0;
        video_cycle(pix, 1'b0, 1'b0);
        repeat (8) begin
            pix.rgb = 24'($urandom);
            video_cycle(pix, 1'b0, 1'b0);
        end
        // blank colour with border off, then on
        pix.h_blank = 1'b1;
        video_cycle(pix, 1'b0, 1'b0);
        bridge_write(`ADDR_BORDER, 32'h1);
        check_video("video", expected_video(pix, 1'b0, 1'b0), video);
        pix.h_blank = 1'b0;
        pix.v_blank = 1'b1;
        video_cycle(pix, 1'b0, 1'b0);
        bridge_write(`ADDR_BORDER, 32'h0);
        check_video("video", expected_video(pix, 1'b0, 1'b0), video);
        pix.v_blank = 1'b0;
        bridge_write(`ADDR_GRAY, 32'h1);
        repeat (8) begin
            pix.rgb = 24'($urandom);
            video_cycle(pix, 1'b0, 1'b0);
        end
        pix.v_blank = 1'b1;
        video_cycle(pix, 1'b0, 1'b0);
        pix.v_blank = 1'b0;
        bridge_write(`ADDR_GRAY, 32'h0);
        // hs pulse trails the rise while vs follows it at once
        for (int i = 0; i <= `HS_DELAY + 3; i++) begin
            pix.hs = (i < 3);
            video_cycle(pix, i == `HS_DELAY, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            pix.vs = (i < 3);
            video_cycle(pix, 1'b0, i == 0);
        end
    endtask

    initial begin
        seed = 7;
        void'($urandom(seed));
        rst_n                    = 1'b0;
        bridge_wr                = 1'b0;
        bridge_addr              = '0;
        bridge_wr_data           = '0;
        dataslot_requestwrite    = 1'b0;
        dataslot_requestwrite_id = '0;
        dataslot_allcomplete     = 1'b0;
        ioctl_wr                 = 1'b0;
        ioctl_dout               = '0;
        ff_button                = 1'b0;
        lcd                      = '0;
        audio_in                 = '0;
        exp_set                  = '0;
        exp_pal                  = `PALETTE_RESET;
        repeat (3) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;
        tick();
        test_settings();
        test_reset_downloads();
        test_palette();
        test_fast_forward();
        test_video();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_macros.svh"

module video_out (
    input  wire                         clk_sys,
    input  wire                         rst_n,
    input  wire gbcore_pkg::lcd_t       lcd,
    input  wire gbcore_pkg::settings_t  settings,
    output gbcore_pkg::video_t          video
);

    localparam int hs_cnt_w = $clog2(`HS_DELAY + 1);

    logic                de_in;
    logic                de_q;
    logic                hs_prev;
    logic                vs_prev;
    logic                hs_q;
    logic                vs_q;
    logic [hs_cnt_w-1:0] hs_cnt;
    logic [`RGB_W-1:0]   rgb_q;
    logic [7:0]          lum;

    assign de_in = !(lcd.h_blank || lcd.v_blank);

    ////////////////////////////////////////////////////////////////////////////
    // sync and enable re-timing

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            de_q    <= 1'b0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
            hs_cnt  <= '0;
        end else begin
            de_q    <= de_in;
            hs_prev <= lcd.hs;
            vs_prev <= lcd.vs;

            // hs pushed late so it never lands on the vs pulse
            if (!hs_prev && lcd.hs) begin
                hs_cnt <= hs_cnt_w'(`HS_DELAY);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
            hs_q <= (hs_cnt == hs_cnt_w'(1));

            // single cycle on the vs rise
            vs_q <= !vs_prev && lcd.vs;
        end
    end

    always_ff @(posedge clk_sys) begin
        rgb_q <= lcd.rgb;
    end

    ////////////////////////////////////////////////////////////////////////////
    // colour select

    // approx 0.28 r + 0.56 g + 0.09 b
    assign lum = (rgb_q[23:16] >> 2) + (rgb_q[23:16] >> 5) +
                 (rgb_q[15:8] >> 1)  + (rgb_q[15:8] >> 4)  +
                 (rgb_q[7:0] >> 4)   + (rgb_q[7:0] >> 5);

    always_comb begin
        video.de = de_q;
        video.hs = hs_q;
        video.vs = vs_q;
        if (!de_q) begin
            // black behind the border, dark green tag otherwise
            video.rgb = settings.sgb_border_en ? '0 : `BLANK_RGB_NO_BORDER;
        end else if (settings.gray_en) begin
            video.rgb = {lum, lum, lum};
        end else begin
            video.rgb = rgb_q;
        end
    end

endmodule

`default_nettype wire
